// File: fir_pkg.sv
package fir_pkg;

    ////////////////////
    // widths and sizes
    ////////////////////
    localparam int data_w    = 32;
    localparam int addr_w    = 12;
    localparam int num_taps  = 11;
    localparam int tap_idx_w = 4;

    // index of the oldest tap, also the wrap point of the sample pointer
    localparam logic [tap_idx_w-1:0] last_tap = tap_idx_w'(num_taps - 1);

    ////////////////////
    // axi-lite address map
    ////////////////////
    localparam logic [addr_w-1:0] addr_ap_ctrl   = 12'h000;
    // coefficient k at base + 4k
    localparam logic [addr_w-1:0] addr_coef_base = 12'h020;

    ////////////////////
    // engine fsm states
    ////////////////////
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_wait = 2'd1;
    localparam logic [1:0] st_step = 2'd2;
    localparam logic [1:0] st_hold = 2'd3;

    // control word at addr_ap_ctrl
    typedef struct packed {
        logic [28:0] reserved;
        logic        idle;
        logic        done;
        logic        start;
    } ap_ctrl_t;

    // one axi-lite data word, raw coefficient or control bits
    typedef union packed {
        logic [data_w-1:0] raw;
        ap_ctrl_t          ctrl;
    } fir_word_u;

endpackage

// File: fir_tap_if.sv
`timescale 1ns/100ps

interface fir_tap_if;

    // step request from the controller
    logic [fir_pkg::tap_idx_w-1:0] tap_idx;
    logic                          step_valid;
    logic                          step_first;
    logic                          step_last;

    // operands, one cycle after tap_idx
    logic signed [fir_pkg::data_w-1:0] coef;
    logic signed [fir_pkg::data_w-1:0] sample;

    modport ctrl (
        output tap_idx, step_valid, step_first, step_last
    );

    modport coef_src (
        input  tap_idx,
        output coef
    );

    modport sample_src (
        input  tap_idx,
        output sample
    );

    modport mac (
        input step_valid, step_first, step_last, coef, sample
    );

endinterface

// File: fir_axil_regs.sv
`timescale 1ns/100ps

module fir_axil_regs (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic [fir_pkg::addr_w-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [fir_pkg::data_w-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [fir_pkg::addr_w-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [fir_pkg::data_w-1:0]  rdata,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        engine_idle,
    input  logic                        run_done,
    output logic                        start,
    fir_tap_if.coef_src                 tap
);

    logic [fir_pkg::data_w-1:0] coef_mem [fir_pkg::num_taps];
    logic                       wr_ack;
    logic                       wr_fire;
    logic                       rd_fire;
    logic                       start_req;
    logic                       ap_idle;
    logic                       ap_done;
    fir_pkg::fir_word_u         wr_word;
    fir_pkg::fir_word_u         ctrl_word;

    // word-aligned address inside the coefficient window
    function automatic logic coef_hit(input logic [fir_pkg::addr_w-1:0] addr);
        logic [fir_pkg::addr_w-1:0] offset;
        offset = addr - fir_pkg::addr_coef_base;
        return (addr >= fir_pkg::addr_coef_base) && (offset[1:0] == 2'b00) &&
               (offset[fir_pkg::addr_w-1:2] < fir_pkg::num_taps);
    endfunction

    function automatic logic [fir_pkg::tap_idx_w-1:0] coef_index(
        input logic [fir_pkg::addr_w-1:0] addr
    );
        logic [fir_pkg::addr_w-1:0] offset;
        offset = addr - fir_pkg::addr_coef_base;
        return offset[fir_pkg::tap_idx_w+1:2];
    endfunction

    assign awready = wr_ack;
    assign wready  = wr_ack;
    assign wr_fire = awvalid && wvalid && wr_ack;
    assign rd_fire = arvalid && arready;
    assign wr_word.raw = wdata;

    assign start_req = wr_fire && (awaddr == fir_pkg::addr_ap_ctrl) &&
                       wr_word.ctrl.start && ap_idle && engine_idle;

    always_comb begin
        ctrl_word.raw        = '0;
        ctrl_word.ctrl.idle  = ap_idle;
        ctrl_word.ctrl.done  = ap_done;
    end

    ////////////////////
    // handshakes and ap_ctrl
    ////////////////////
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_ack  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            start   <= 1'b0;
            ap_idle <= 1'b1;
            ap_done <= 1'b0;
        end else begin
            wr_ack  <= awvalid && wvalid && !wr_ack;
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            start <= start_req;
            if (start_req) begin
                ap_idle <= 1'b0;
            end else if (run_done) begin
                ap_idle <= 1'b1;
            end
            // done is read-to-clear
            if (run_done) begin
                ap_done <= 1'b1;
            end else if (rd_fire && araddr == fir_pkg::addr_ap_ctrl) begin
                ap_done <= 1'b0;
            end
        end
    end

    ////////////////////
    // coefficient store
    ////////////////////
    always_ff @(posedge axis_clk) begin
        if (wr_fire && ap_idle && coef_hit(awaddr)) begin
            coef_mem[coef_index(awaddr)] <= wr_word.raw;
        end
        if (rd_fire) begin
            if (araddr == fir_pkg::addr_ap_ctrl) begin
                rdata <= ctrl_word.raw;
            end else if (coef_hit(araddr)) begin
                rdata <= coef_mem[coef_index(araddr)];
            end else begin
                rdata <= '0;
            end
        end
        tap.coef <= coef_mem[tap.tap_idx];
    end

endmodule

// File: fir_sample_buf.sv
`timescale 1ns/100ps

module fir_sample_buf (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        clear,
    input  logic                        push,
    input  logic [fir_pkg::data_w-1:0]  push_data,
    fir_tap_if.sample_src               tap
);

    logic [fir_pkg::data_w-1:0]    mem [fir_pkg::num_taps];
    logic [fir_pkg::tap_idx_w-1:0] wr_ptr;
    logic [fir_pkg::tap_idx_w-1:0] wr_next;
    logic [fir_pkg::tap_idx_w-1:0] rd_idx;

    // wr_ptr always points at the newest sample
    assign wr_next = (wr_ptr == fir_pkg::last_tap) ? '0 : wr_ptr + 1'b1;

    // index k counts back from the newest, wrapping below slot 0
    always_comb begin
        if (tap.tap_idx > wr_ptr) begin
            rd_idx = wr_ptr + (fir_pkg::last_tap - tap.tap_idx) + 1'b1;
        end else begin
            rd_idx = wr_ptr - tap.tap_idx;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n || clear) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_next;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (clear) begin
            for (int i = 0; i < fir_pkg::num_taps; i++) begin
                mem[i] <= '0;
            end
        end else if (push) begin
            mem[wr_next] <= push_data;
        end
        tap.sample <= mem[rd_idx];
    end

endmodule

// File: fir_ctrl.sv
`timescale 1ns/100ps

module fir_ctrl (
    input  logic   axis_clk,
    input  logic   axis_rst_n,
    input  logic   start,
    input  logic   ss_tvalid,
    input  logic   ss_tlast,
    input  logic   result_valid,
    input  logic   sm_tready,
    output logic   ss_tready,
    output logic   push,
    output logic   clear,
    output logic   engine_idle,
    output logic   run_done,
    output logic   result_taken,
    output logic   sm_tlast,
    fir_tap_if.ctrl tap
);

    logic [1:0]                    state;
    logic [fir_pkg::tap_idx_w-1:0] tap_cnt;
    logic                          last_q;

    ////////////////////
    // stream side
    ////////////////////
    assign engine_idle = (state == fir_pkg::st_idle);
    assign clear       = engine_idle && start;
    assign ss_tready   = (state == fir_pkg::st_wait);
    assign push        = ss_tvalid && ss_tready;

    // output held in st_hold until the sink takes it
    assign result_taken = (state == fir_pkg::st_hold) && result_valid && sm_tready;
    assign run_done     = result_taken && last_q;
    assign sm_tlast     = (state == fir_pkg::st_hold) && last_q;

    ////////////////////
    // tap steps
    ////////////////////
    assign tap.tap_idx    = tap_cnt;
    assign tap.step_valid = (state == fir_pkg::st_step);
    assign tap.step_first = (state == fir_pkg::st_step) && (tap_cnt == '0);
    assign tap.step_last  = (state == fir_pkg::st_step) && (tap_cnt == fir_pkg::last_tap);

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state   <= fir_pkg::st_idle;
            tap_cnt <= '0;
            last_q  <= 1'b0;
        end else begin
            case (state)
                fir_pkg::st_idle: begin
                    if (start) begin
                        last_q <= 1'b0;
                        state  <= fir_pkg::st_wait;
                    end
                end
                fir_pkg::st_wait: begin
                    if (push) begin
                        last_q  <= ss_tlast;
                        tap_cnt <= '0;
                        state   <= fir_pkg::st_step;
                    end
                end
                fir_pkg::st_step: begin
                    if (tap_cnt == fir_pkg::last_tap) begin
                        state <= fir_pkg::st_hold;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                default: begin
                    // tlast sample closes the run
                    if (result_taken) begin
                        state <= last_q ? fir_pkg::st_idle : fir_pkg::st_wait;
                    end
                end
            endcase
        end
    end

endmodule

// File: fir_mac.sv
`timescale 1ns/100ps

module fir_mac (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        result_taken,
    output logic [fir_pkg::data_w-1:0]  result,
    output logic                        result_valid,
    fir_tap_if.mac                      tap
);

    logic                              d_valid;
    logic                              d_first;
    logic                              d_last;
    logic signed [fir_pkg::data_w-1:0] product;
    logic signed [fir_pkg::data_w-1:0] sum;
    logic signed [fir_pkg::data_w-1:0] acc;

    // operands arrive one cycle after the step, wraps to 32 bits
    assign product = tap.coef * tap.sample;
    assign sum     = d_first ? product : acc + product;

    // flags delayed to line up with coef and sample
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            d_valid      <= 1'b0;
            d_first      <= 1'b0;
            d_last       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            d_valid <= tap.step_valid;
            d_first <= tap.step_first;
            d_last  <= tap.step_last;
            if (d_valid && d_last) begin
                result_valid <= 1'b1;
            end else if (result_taken) begin
                result_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (d_valid) begin
            acc <= sum;
        end
        if (d_valid && d_last) begin
            result <= sum;
        end
    end

endmodule

// File: fir.sv
`timescale 1ns/100ps

module fir (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    // axi-lite
    input  logic [fir_pkg::addr_w-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [fir_pkg::data_w-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [fir_pkg::addr_w-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [fir_pkg::data_w-1:0]  rdata,
    output logic                        rvalid,
    input  logic                        rready,
    // axi-stream in
    input  logic                        ss_tvalid,
    input  logic [fir_pkg::data_w-1:0]  ss_tdata,
    input  logic                        ss_tlast,
    output logic                        ss_tready,
    // axi-stream out
    input  logic                        sm_tready,
    output logic                        sm_tvalid,
    output logic [fir_pkg::data_w-1:0]  sm_tdata,
    output logic                        sm_tlast
);

    logic start;
    logic engine_idle;
    logic run_done;
    logic push;
    logic clear;
    logic result_taken;

    fir_tap_if tap_bus ();

    fir_axil_regs i_regs (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rready       (rready),
        .engine_idle  (engine_idle),
        .run_done     (run_done),
        .start        (start),
        .tap          (tap_bus.coef_src)
    );

    fir_sample_buf i_sample_buf (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .clear        (clear),
        .push         (push),
        .push_data    (ss_tdata),
        .tap          (tap_bus.sample_src)
    );

    fir_ctrl i_ctrl (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .start        (start),
        .ss_tvalid    (ss_tvalid),
        .ss_tlast     (ss_tlast),
        .result_valid (sm_tvalid),
        .sm_tready    (sm_tready),
        .ss_tready    (ss_tready),
        .push         (push),
        .clear        (clear),
        .engine_idle  (engine_idle),
        .run_done     (run_done),
        .result_taken (result_taken),
        .sm_tlast     (sm_tlast),
        .tap          (tap_bus.ctrl)
    );

    // output sample straight from the mac register
    fir_mac i_mac (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .result_taken (result_taken),
        .result       (sm_tdata),
        .result_valid (sm_tvalid),
        .tap          (tap_bus.mac)
    );

endmodule

// File: fir_sva.sv
`timescale 1ns/100ps

module fir_sva (
    input logic                       axis_clk,
    input logic                       axis_rst_n,
    input logic                       awready,
    input logic                       wready,
    input logic                       arready,
    input logic                       rvalid,
    input logic                       rready,
    input logic [fir_pkg::data_w-1:0] rdata,
    input logic                       ss_tready,
    input logic                       sm_tvalid,
    input logic                       sm_tready,
    input logic                       sm_tlast,
    input logic [fir_pkg::data_w-1:0] sm_tdata
);

    ////////////////////
    // axi-lite
    ////////////////////
    // handshake outputs start low out of reset
    assert property (@(posedge axis_clk)
        $rose(axis_rst_n) |-> !awready && !wready && !arready && !rvalid &&
                              !ss_tready && !sm_tvalid)
        else $error("handshake output high right after reset");

    // write handshake lasts one cycle
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready |=> !awready) else $error("awready held longer than one cycle");

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        arready |=> !arready) else $error("arready held longer than one cycle");

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read data dropped or changed before rready");

    ////////////////////
    // axi-stream
    ////////////////////
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
        else $error("output sample changed under back-pressure");

    // no new input while an output is pending
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid)) else $error("input accepted with output pending");

endmodule

bind fir fir_sva i_fir_sva (.*);

// File: tb_fir.sv
`timescale 1ns/100ps

module tb_fir;

    logic                          axis_clk;
    logic                          axis_rst_n;
    logic [fir_pkg::addr_w-1:0]    awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [fir_pkg::data_w-1:0]    wdata;
    logic                          wvalid;
    logic                          wready;
    logic [fir_pkg::addr_w-1:0]    araddr;
    logic                          arvalid;
    logic                          arready;
    logic [fir_pkg::data_w-1:0]    rdata;
    logic                          rvalid;
    logic                          rready;
    logic                          ss_tvalid;
    logic [fir_pkg::data_w-1:0]    ss_tdata;
    logic                          ss_tlast;
    logic                          ss_tready;
    logic                          sm_tready;
    logic                          sm_tvalid;
    logic [fir_pkg::data_w-1:0]    sm_tdata;
    logic                          sm_tlast;

    // one queue entry per trace line
    byte                           op_q[$];
    logic [31:0]                   arg_a_q[$];
    logic [31:0]                   arg_b_q[$];
    integer                        seed;
    int                            cycle_cnt = 0;
    int                            cycle_limit = 0;

    fir i_fir (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(posedge axis_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding",
                                cycle_cnt));
        end
    end

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_word(input string name, input fir_pkg::fir_word_u got,
                              input fir_pkg::fir_word_u exp);
        if (got.raw !== exp.raw) begin
            abort_run($sformatf("error: %s got %h expected %h", name, got.raw, exp.raw));
        end
    endtask

    task automatic check_ctrl(input fir_pkg::fir_word_u got, input fir_pkg::fir_word_u exp);
        if (got.ctrl.idle !== exp.ctrl.idle) begin
            abort_run($sformatf("error: ap_ctrl.idle got %h expected %h",
                                got.ctrl.idle, exp.ctrl.idle));
        end else if (got.ctrl.done !== exp.ctrl.done) begin
            abort_run($sformatf("error: ap_ctrl.done got %h expected %h",
                                got.ctrl.done, exp.ctrl.done));
        end else begin
            check_word("ap_ctrl", got, exp);
        end
    endtask

    task automatic check_last(input bit got, input bit exp);
        if (got !== exp) begin
            abort_run($sformatf("error: sm_tlast got %h expected %h", got, exp));
        end
    endtask

    ////////////////////
    // bus drivers
    ////////////////////
    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    task automatic axil_write(input logic [fir_pkg::addr_w-1:0] addr,
                              input logic [fir_pkg::data_w-1:0] data);
        logic fired;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        fired   = 1'b0;
        while (!fired) begin
            fired = awready && wready;
            next_cycle();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [fir_pkg::addr_w-1:0] addr,
                             output fir_pkg::fir_word_u data);
        logic fired;
        araddr  = addr;
        arvalid = 1'b1;
        fired   = 1'b0;
        while (!fired) begin
            fired = arready;
            next_cycle();
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) begin
            next_cycle();
        end
        data.raw = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic send_sample(input logic [fir_pkg::data_w-1:0] data, input bit last);
        logic fired;
        ss_tdata  = data;
        ss_tlast  = last;
        ss_tvalid = 1'b1;
        fired     = 1'b0;
        while (!fired) begin
            fired = ss_tready;
            next_cycle();
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    // random back-pressure on the output side
    task automatic expect_output(input fir_pkg::fir_word_u exp, input bit exp_last);
        logic               taken;
        fir_pkg::fir_word_u got;
        taken = 1'b0;
        while (!taken) begin
            sm_tready = 1'($random(seed));
            if (sm_tvalid && sm_tready) begin
                taken   = 1'b1;
                got.raw = sm_tdata;
                check_word("sm_tdata", got, exp);
                check_last(sm_tlast, exp_last);
            end
            next_cycle();
        end
        sm_tready = 1'b0;
    endtask

    task automatic load_trace();
        int          fd;
        int          code;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("fir_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open fir_trace.txt for reading");
        end else begin
            while ($fgets(line, fd) > 0) begin
                op = line.getc(0);
                if (op == "C" || op == "R" || op == "G" || op == "S" || op == "E") begin
                    a = '0;
                    b = '0;
                    code = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    if (op != "G" && code != 2) begin
                        abort_run($sformatf("malformed trace line: %s", line));
                    end else begin
                        op_q.push_back(op);
                        arg_a_q.push_back(a);
                        arg_b_q.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        fir_pkg::fir_word_u got;
        fir_pkg::fir_word_u exp;
        axis_rst_n = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        seed       = 32'ha12aa3a9;
        load_trace();
        cycle_limit = op_q.size() * (fir_pkg::num_taps + 10);
        repeat (2) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        foreach (op_q[i]) begin
            exp.raw = arg_b_q[i];
            case (op_q[i])
                "C": axil_write(arg_a_q[i][fir_pkg::addr_w-1:0], arg_b_q[i]);
                "R": begin
                    axil_read(arg_a_q[i][fir_pkg::addr_w-1:0], got);
                    if (arg_a_q[i][fir_pkg::addr_w-1:0] == fir_pkg::addr_ap_ctrl) begin
                        check_ctrl(got, exp);
                    end else begin
                        check_word("rdata", got, exp);
                    end
                end
                "G": axil_write(fir_pkg::addr_ap_ctrl, 32'h0000_0001);
                "S": send_sample(arg_a_q[i], arg_b_q[i][0]);
                default: begin
                    exp.raw = arg_a_q[i];
                    expect_output(exp, arg_b_q[i][0]);
                end
            endcase
        end
        next_cycle();
        if (sm_tvalid) begin
            abort_run("an output sample is still pending after the last trace record");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: fir_trace.txt
# C addr coef : write coefficient   R addr value : read and compare   G : start a run
# S data last : send input sample   E data last : expected output sample
R 000 00000004
C 020 00000001
C 024 00000002
C 028 FFFFFFFF
C 02C 00000003
C 030 00000000
C 034 FFFFFFFE
C 038 00000004
C 03C 00000001
C 040 00000000
C 044 FFFFFFFD
C 048 00000005
R 028 FFFFFFFF
R 100 00000000
G
C 020 00000063
S 00000005 0
E 00000005 0
S FFFFFFFD 0
E 00000007 0
S 00000010 0
E 00000005 0
S 7FFFFFFF 1
E 80000031 1
R 000 00000006
R 000 00000004
R 020 00000001
G
S 00000002 0
E 00000002 0
S FFFFFFFF 1
E 00000003 1
R 000 00000006

// File: fir.f
fir_pkg.sv
fir_tap_if.sv
fir_axil_regs.sv
fir_sample_buf.sv
fir_ctrl.sv
fir_mac.sv
fir.sv
fir_sva.sv
tb_fir.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the fir testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fir \
    -f fir.f -Mdir obj_dir -o sim_fir

./obj_dir/sim_fir > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
